// ==== filelist.f ====
mips_pkg.sv
mc_decoder.sv
mc_controller.sv
mc_regfile.sv
mc_alu_stage.sv
mc_cpu.sv
tb_mc_cpu_sva.sv
tb_mc_cpu.sv

// ==== mc_alu_stage.sv ====
`timescale 1ns/1ps

module mc_alu_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  mips_pkg::alu_a_sel_e a_sel_i,
    input  mips_pkg::alu_b_sel_e b_sel_i,
    input  mips_pkg::alu_op_e    op_i,
    input  mips_pkg::word_t      pc_i,
    input  mips_pkg::word_t      rs_data_i,
    input  mips_pkg::word_t      rt_data_i,
    input  logic [15:0]          imm16_i,
    input  logic                 imm_zero_ext_i,
    input  logic                 z_we_i,
    output mips_pkg::word_t      z_o,
    output logic                 zero_o
);

    import mips_pkg::*;

    word_t imm_ext;
    word_t br_ofs;
    word_t alu_a;
    word_t alu_b;
    word_t result;
    word_t z_q;

    ////////////////////////////////////////////////////////////////////////////
    // Immediate extension
    ////////////////////////////////////////////////////////////////////////////
    assign imm_ext = imm_zero_ext_i ? {16'h0000, imm16_i}
                                    : {{16{imm16_i[15]}}, imm16_i};

    // Word offset for branches
    assign br_ofs = {{14{imm16_i[15]}}, imm16_i, 2'b00};

    ////////////////////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////////////////////
    assign alu_a = (a_sel_i == A_PC) ? pc_i : rs_data_i;

    always_comb begin
        case (b_sel_i)
            B_IMM:    alu_b = imm_ext;
            B_BR_OFS: alu_b = br_ofs;
            default:  alu_b = rt_data_i;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (op_i)
            ALU_SUB: result = alu_a - alu_b;
            ALU_AND: result = alu_a & alu_b;
            ALU_OR:  result = alu_a | alu_b;
            ALU_SLT: begin
                // Signed compare
                result = ($signed(alu_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
            end
            ALU_LUI: result = {alu_b[15:0], 16'h0000};
            default: result = alu_a + alu_b;
        endcase
    end

    // Flag for the beq compare, taken from the live result
    assign zero_o = (result == '0);

    // Z result register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            z_q <= '0;
        end else if (z_we_i) begin
            z_q <= result;
        end
    end

    assign z_o = z_q;

endmodule

// ==== mc_controller.sv ====
`timescale 1ns/1ps

module mc_controller (
    input  logic                   clk,
    input  logic                   rst,
    input  mips_pkg::instr_class_e class_i,
    input  mips_pkg::alu_op_e      alu_op_i,
    input  logic                   zero_i,
    output logic                   pc_we_o,
    output logic                   ir_we_o,
    output logic                   z_we_o,
    output logic                   drr_we_o,
    output logic                   gr_we_o,
    output logic                   dmem_read_o,
    output logic                   dmem_write_o,
    output mips_pkg::alu_a_sel_e   alu_a_sel_o,
    output mips_pkg::alu_b_sel_e   alu_b_sel_o,
    output mips_pkg::alu_op_e      alu_op_o,
    output mips_pkg::wb_sel_e      wb_sel_o,
    output mips_pkg::pc_sel_e      pc_sel_o,
    output logic                   gr_dst_rd_o
);

    import mips_pkg::*;

    state_e state;
    state_e state_next;

    ////////////////////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = FETCH;
        case (state)
            FETCH: state_next = DECODE;
            DECODE: begin
                // Jumps and no-ops are done after decode
                if (class_i == CL_JUMP || class_i == CL_NOP) begin
                    state_next = FETCH;
                end else begin
                    state_next = EXECUTE;
                end
            end
            EXECUTE: begin
                case (class_i)
                    CL_LOAD, CL_STORE:  state_next = MEMORY;
                    CL_ALU_R, CL_ALU_I: state_next = WRITEBACK;
                    default:            state_next = FETCH;
                endcase
            end
            MEMORY: begin
                if (class_i == CL_LOAD) begin
                    state_next = WRITEBACK;
                end
            end
            default: state_next = FETCH;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Strobes and selects, one cycle each
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        pc_we_o      = 1'b0;
        ir_we_o      = 1'b0;
        z_we_o       = 1'b0;
        drr_we_o     = 1'b0;
        gr_we_o      = 1'b0;
        dmem_read_o  = 1'b0;
        dmem_write_o = 1'b0;
        alu_a_sel_o  = A_RS;
        alu_b_sel_o  = B_RT;
        alu_op_o     = ALU_ADD;
        wb_sel_o     = WB_Z;
        pc_sel_o     = PC_PLUS4;
        gr_dst_rd_o  = 1'b0;
        case (state)
            FETCH: begin
                ir_we_o = 1'b1;
                pc_we_o = 1'b1;
            end
            DECODE: begin
                // Branch target computed ahead, PC already holds PC+4
                alu_a_sel_o = A_PC;
                alu_b_sel_o = B_BR_OFS;
                z_we_o      = 1'b1;
                if (class_i == CL_JUMP) begin
                    pc_we_o  = 1'b1;
                    pc_sel_o = PC_JUMP;
                end
            end
            EXECUTE: begin
                case (class_i)
                    CL_ALU_R: begin
                        alu_op_o = alu_op_i;
                        z_we_o   = 1'b1;
                    end
                    CL_ALU_I: begin
                        alu_b_sel_o = B_IMM;
                        alu_op_o    = alu_op_i;
                        z_we_o      = 1'b1;
                    end
                    CL_LOAD, CL_STORE: begin
                        alu_b_sel_o = B_IMM;
                        z_we_o      = 1'b1;
                    end
                    CL_BRANCH: begin
                        // Z keeps the target, rs - rt only sets the flag
                        alu_op_o = ALU_SUB;
                        pc_sel_o = PC_Z;
                        pc_we_o  = zero_i;
                    end
                    default: ;
                endcase
            end
            MEMORY: begin
                if (class_i == CL_LOAD) begin
                    dmem_read_o = 1'b1;
                    drr_we_o    = 1'b1;
                end else begin
                    dmem_write_o = 1'b1;
                end
            end
            WRITEBACK: begin
                gr_we_o     = 1'b1;
                gr_dst_rd_o = (class_i == CL_ALU_R);
                wb_sel_o    = (class_i == CL_LOAD) ? WB_DRR : WB_Z;
            end
            default: ;
        endcase
    end

endmodule

// ==== mc_cpu.sv ====
`timescale 1ns/1ps

module mc_cpu (
    input  logic            clk,
    input  logic            rst,
    input  mips_pkg::word_t instr_i,
    input  mips_pkg::word_t dmem_rdata_i,
    output mips_pkg::word_t imem_addr_o,
    output mips_pkg::word_t dmem_addr_o,
    output mips_pkg::word_t dmem_wdata_o,
    output logic            dmem_read_o,
    output logic            dmem_write_o
);

    import mips_pkg::*;

    // Architectural and holding registers
    word_t pc;
    word_t pc_next;
    word_t ir;
    word_t drr;

    // Decoder outputs
    instr_class_e instr_class;
    reg_addr_t    rs;
    reg_addr_t    rt;
    reg_addr_t    rd;
    logic [15:0]  imm16;
    logic [25:0]  jidx;
    logic         imm_zero_ext;
    alu_op_e      dec_alu_op;

    // Controller outputs
    logic       pc_we;
    logic       ir_we;
    logic       z_we;
    logic       drr_we;
    logic       gr_we;
    logic       gr_dst_rd;
    alu_a_sel_e alu_a_sel;
    alu_b_sel_e alu_b_sel;
    alu_op_e    alu_op;
    wb_sel_e    wb_sel;
    pc_sel_e    pc_sel;

    // Datapath
    word_t     rs_data;
    word_t     rt_data;
    word_t     z;
    logic      alu_zero;
    word_t     gr_wdata;
    reg_addr_t gr_waddr;

    mc_decoder mc_decoder_i (
        .instr_i        (ir),
        .class_o        (instr_class),
        .rs_o           (rs),
        .rt_o           (rt),
        .rd_o           (rd),
        .imm16_o        (imm16),
        .jidx_o         (jidx),
        .imm_zero_ext_o (imm_zero_ext),
        .alu_op_o       (dec_alu_op)
    );

    mc_controller mc_controller_i (
        .clk          (clk),
        .rst          (rst),
        .class_i      (instr_class),
        .alu_op_i     (dec_alu_op),
        .zero_i       (alu_zero),
        .pc_we_o      (pc_we),
        .ir_we_o      (ir_we),
        .z_we_o       (z_we),
        .drr_we_o     (drr_we),
        .gr_we_o      (gr_we),
        .dmem_read_o  (dmem_read_o),
        .dmem_write_o (dmem_write_o),
        .alu_a_sel_o  (alu_a_sel),
        .alu_b_sel_o  (alu_b_sel),
        .alu_op_o     (alu_op),
        .wb_sel_o     (wb_sel),
        .pc_sel_o     (pc_sel),
        .gr_dst_rd_o  (gr_dst_rd)
    );

    mc_regfile mc_regfile_i (
        .clk      (clk),
        .rst      (rst),
        .raddr1_i (rs),
        .raddr2_i (rt),
        .waddr_i  (gr_waddr),
        .we_i     (gr_we),
        .wdata_i  (gr_wdata),
        .rdata1_o (rs_data),
        .rdata2_o (rt_data)
    );

    mc_alu_stage mc_alu_stage_i (
        .clk            (clk),
        .rst            (rst),
        .a_sel_i        (alu_a_sel),
        .b_sel_i        (alu_b_sel),
        .op_i           (alu_op),
        .pc_i           (pc),
        .rs_data_i      (rs_data),
        .rt_data_i      (rt_data),
        .imm16_i        (imm16),
        .imm_zero_ext_i (imm_zero_ext),
        .z_we_i         (z_we),
        .z_o            (z),
        .zero_o         (alu_zero)
    );

    ////////////////////////////////////////////////////////////////////////////
    // PC and next-PC selection
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (pc_sel)
            PC_Z:    pc_next = z;
            // pc already points past the jump
            PC_JUMP: pc_next = {pc[31:28], jidx, 2'b00};
            default: pc_next = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (pc_we) begin
            pc <= pc_next;
        end
    end

    // IR clears to an all-zero word, which decodes as a no-op
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ir <= '0;
        end else if (ir_we) begin
            ir <= instr_i;
        end
    end

    // Load data captured at the end of MEMORY
    always_ff @(posedge clk) begin
        if (drr_we) begin
            drr <= dmem_rdata_i;
        end
    end

    // Write-back data and destination
    assign gr_wdata = (wb_sel == WB_DRR) ? drr : z;
    assign gr_waddr = gr_dst_rd ? rd : rt;

    // Memory ports
    assign imem_addr_o  = pc;
    assign dmem_addr_o  = z;
    assign dmem_wdata_o = rt_data;

endmodule

// ==== mc_decoder.sv ====
`timescale 1ns/1ps

module mc_decoder (
    input  mips_pkg::word_t        instr_i,
    output mips_pkg::instr_class_e class_o,
    output mips_pkg::reg_addr_t    rs_o,
    output mips_pkg::reg_addr_t    rt_o,
    output mips_pkg::reg_addr_t    rd_o,
    output logic [15:0]            imm16_o,
    output logic [25:0]            jidx_o,
    output logic                   imm_zero_ext_o,
    output mips_pkg::alu_op_e      alu_op_o
);

    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];

    // Plain field slicing
    assign rs_o    = instr_i[25:21];
    assign rt_o    = instr_i[20:16];
    assign rd_o    = instr_i[15:11];
    assign imm16_o = instr_i[15:0];
    assign jidx_o  = instr_i[25:0];

    // Only ori takes its immediate unsigned
    assign imm_zero_ext_o = (opcode == OP_ORI);

    always_comb begin
        class_o  = CL_NOP;
        alu_op_o = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                class_o = CL_ALU_R;
                case (funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    // Unknown function code runs as a no-op
                    default: class_o = CL_NOP;
                endcase
            end
            OP_ADDIU: class_o = CL_ALU_I;
            OP_ORI: begin
                class_o  = CL_ALU_I;
                alu_op_o = ALU_OR;
            end
            OP_LUI: begin
                class_o  = CL_ALU_I;
                alu_op_o = ALU_LUI;
            end
            OP_LW:  class_o = CL_LOAD;
            OP_SW:  class_o = CL_STORE;
            OP_BEQ: begin
                class_o  = CL_BRANCH;
                alu_op_o = ALU_SUB;
            end
            OP_J:    class_o = CL_JUMP;
            default: class_o = CL_NOP;
        endcase
    end

endmodule

// ==== mc_regfile.sv ====
`timescale 1ns/1ps

module mc_regfile (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::reg_addr_t raddr1_i,
    input  mips_pkg::reg_addr_t raddr2_i,
    input  mips_pkg::reg_addr_t waddr_i,
    input  logic                we_i,
    input  mips_pkg::word_t     wdata_i,
    output mips_pkg::word_t     rdata1_o,
    output mips_pkg::word_t     rdata2_o
);

    import mips_pkg::*;

    word_t regs [32];

    // Entry 0 is cleared by reset and never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous read ports
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

// ==== mips_pkg.sv ====
package mips_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Machine word and register index
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // First fetch address after reset
    localparam word_t RESET_PC = 32'h0040_0000;

    // Primary opcodes of the supported subset
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type function field
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath control encodings
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI     // b shifted up by 16
    } alu_op_e;

    typedef enum logic [2:0] {
        CL_ALU_R,
        CL_ALU_I,
        CL_LOAD,
        CL_STORE,
        CL_BRANCH,
        CL_JUMP,
        CL_NOP
    } instr_class_e;

    typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK} state_e;

    typedef enum logic {A_RS, A_PC} alu_a_sel_e;
    typedef enum logic [1:0] {B_RT, B_IMM, B_BR_OFS} alu_b_sel_e;
    typedef enum logic {WB_Z, WB_DRR} wb_sel_e;
    typedef enum logic [1:0] {PC_PLUS4, PC_Z, PC_JUMP} pc_sel_e;

endpackage

// ==== tb_mc_cpu.sv ====
`timescale 1ns/1ps

module tb_mc_cpu;

    import mips_pkg::*;

    localparam word_t DATA_BASE        = 32'h1001_0000;
    localparam int    IMEM_WORDS       = 128;
    localparam int    DMEM_WORDS       = 64;
    localparam int    CYCLES_PER_INSTR = 5;
    localparam int    TIMEOUT_MARGIN   = 100;

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    word_t instr;
    word_t dmem_rdata;
    word_t imem_addr;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_read;
    logic  dmem_write;

    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    int    prog_len = 0;
    int    seed = 60;
    int    cycles = 0;
    int    cycle_limit = TIMEOUT_MARGIN;

    // Predicted stores and the ones seen on the bus
    word_t exp_addr_q[$];
    word_t exp_data_q[$];
    word_t exp_pc_q[$];
    word_t log_addr_q[$];
    word_t log_data_q[$];
    word_t log_pc_q[$];

    mc_cpu mc_cpu_i (
        .clk          (clk),
        .rst          (rst),
        .instr_i      (instr),
        .dmem_rdata_i (dmem_rdata),
        .imem_addr_o  (imem_addr),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_read_o  (dmem_read),
        .dmem_write_o (dmem_write)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Memory models and store monitor
    ////////////////////////////////////////////////////////////////////////////
    function automatic word_t fill_word(word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    // Words past the program are zero, which runs as a no-op
    always_comb begin
        if (imem_addr - RESET_PC < 4 * IMEM_WORDS) begin
            instr = imem[(imem_addr - RESET_PC) >> 2];
        end else begin
            instr = '0;
        end
    end

    // Read data only while the core strobes a read
    always_comb begin
        if (!dmem_read) begin
            dmem_rdata = '0;
        end else if (dmem_addr - DATA_BASE < 4 * DMEM_WORDS) begin
            dmem_rdata = dmem[(dmem_addr - DATA_BASE) >> 2];
        end else begin
            dmem_rdata = fill_word(dmem_addr);
        end
    end

    // Strobes are settled mid-cycle
    always @(negedge clk) begin
        if (!rst && dmem_write) begin
            if (dmem_addr - DATA_BASE < 4 * DMEM_WORDS) begin
                dmem[(dmem_addr - DATA_BASE) >> 2] = dmem_wdata;
            end
            log_addr_q.push_back(dmem_addr);
            log_data_q.push_back(dmem_wdata);
            log_pc_q.push_back(imem_addr);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
            if (cycles > cycle_limit) begin
                $display("timeout: expected stores missing after %0d cycles", cycle_limit);
                stop_on_failure();
            end
        end
    end

    // Memory port assertions end the run at once
    always @(negedge clk) begin
        if (mc_cpu_i.mem_port_checks_i.failed_excl
            || mc_cpu_i.mem_port_checks_i.failed_reset
            || mc_cpu_i.mem_port_checks_i.failed_align) begin
            $display("an assertion on the memory ports failed during the run");
            stop_on_failure();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    task automatic stop_on_failure();
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(string test, word_t exp, word_t act);
        if (act !== exp) begin
            $display("mismatch in %s: data expected %08h, actual %08h", test, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_addr(string test, word_t exp, word_t act);
        if (act !== exp) begin
            $display("mismatch in %s: address expected %08h, actual %08h", test, exp, act);
            stop_on_failure();
        end
    endtask

    // Two's complement order, a negative word is below any positive one
    function automatic word_t signed_less(word_t a, word_t b);
        if (a[31] != b[31]) begin
            return {31'd0, a[31]};
        end
        return {31'd0, a < b};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Program builder
    ////////////////////////////////////////////////////////////////////////////
    task automatic put_word(word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic r_type(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
        put_word({OP_RTYPE, rs, rt, rd, 5'd0, fn});
    endtask

    task automatic i_type(logic [5:0] op, reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
        put_word({op, rs, rt, imm});
    endtask

    task automatic load_const(reg_addr_t rt, word_t value);
        i_type(OP_LUI, rt, 5'd0, value[31:16]);
        i_type(OP_ORI, rt, rt, value[15:0]);
    endtask

    task automatic jump_to(int idx);
        word_t target;
        target = RESET_PC + 4 * idx;
        put_word({OP_J, target[27:2]});
    endtask

    function automatic logic [15:0] next_ofs();
        return 16'(4 * exp_addr_q.size());
    endfunction

    // Base register 1 holds DATA_BASE
    task automatic store_expect(reg_addr_t rt, logic [15:0] ofs, word_t data);
        exp_addr_q.push_back(DATA_BASE + ofs);
        exp_data_q.push_back(data);
        // PC is already past the store in MEMORY
        exp_pc_q.push_back(RESET_PC + 4 * prog_len + 4);
        i_type(OP_SW, rt, 5'd1, ofs);
    endtask

    task automatic begin_test();
        @(posedge clk);
        #1;
        rst = 1'b1;
        prog_len = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_word(DATA_BASE + 4 * i);
        end
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_pc_q.delete();
        log_addr_q.delete();
        log_data_q.delete();
        log_pc_q.delete();
    endtask

    task automatic run_and_check(string test);
        cycle_limit = CYCLES_PER_INSTR * prog_len + TIMEOUT_MARGIN;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        while (log_addr_q.size() < exp_addr_q.size()) begin
            @(posedge clk);
        end
        foreach (exp_addr_q[i]) begin
            check_addr(test, exp_addr_q[i], log_addr_q[i]);
            check_word(test, exp_data_q[i], log_data_q[i]);
            check_addr(test, exp_pc_q[i], log_pc_q[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_reset_fetch();
        begin_test();
        cycle_limit = TIMEOUT_MARGIN;
        #1;
        check_addr("reset_fetch", RESET_PC, imem_addr);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_addr("reset_fetch", RESET_PC, imem_addr);
        // First FETCH consumes the reset address
        @(posedge clk);
        #1;
        check_addr("reset_fetch", RESET_PC + 4, imem_addr);
    endtask

    task automatic test_reg_alu();
        word_t a;
        word_t b;
        begin_test();
        load_const(5'd1, DATA_BASE);
        for (int k = 0; k < 5; k++) begin
            a = $random(seed);
            b = $random(seed);
            if (k == 4) begin
                // Signed and unsigned order disagree here
                a = 32'h8000_0000;
                b = 32'h0000_0001;
            end
            load_const(5'd2, a);
            load_const(5'd3, b);
            r_type(FN_ADDU, 5'd4, 5'd2, 5'd3);
            r_type(FN_SUBU, 5'd5, 5'd2, 5'd3);
            r_type(FN_AND, 5'd6, 5'd2, 5'd3);
            r_type(FN_OR, 5'd7, 5'd2, 5'd3);
            r_type(FN_SLT, 5'd8, 5'd2, 5'd3);
            store_expect(5'd4, next_ofs(), a + b);
            store_expect(5'd5, next_ofs(), a - b);
            store_expect(5'd6, next_ofs(), a & b);
            store_expect(5'd7, next_ofs(), a | b);
            store_expect(5'd8, next_ofs(), signed_less(a, b));
        end
        run_and_check("reg_alu");
    endtask

    task automatic test_imm_ops();
        word_t       a;
        logic [15:0] imm;
        begin_test();
        load_const(5'd1, DATA_BASE);
        for (int k = 0; k < 4; k++) begin
            a = $random(seed);
            imm = 16'($random(seed));
            // Alternate the sign so both extensions are used
            imm[15] = k[0];
            load_const(5'd2, a);
            i_type(OP_ADDIU, 5'd3, 5'd2, imm);
            i_type(OP_ORI, 5'd4, 5'd2, imm);
            i_type(OP_LUI, 5'd5, 5'd0, imm);
            store_expect(5'd3, next_ofs(), a + {{16{imm[15]}}, imm});
            store_expect(5'd4, next_ofs(), a | {16'h0000, imm});
            store_expect(5'd5, next_ofs(), {imm, 16'h0000});
        end
        run_and_check("imm_ops");
    endtask

    task automatic test_load_store();
        word_t v;
        begin_test();
        v = $random(seed);
        load_const(5'd1, DATA_BASE);
        load_const(5'd2, v);
        store_expect(5'd2, 16'd8, v);
        i_type(OP_LW, 5'd3, 5'd1, 16'd8);
        store_expect(5'd3, 16'd20, v);
        // Untouched word still holds its fill pattern
        i_type(OP_LW, 5'd4, 5'd1, 16'd40);
        store_expect(5'd4, 16'd24, fill_word(DATA_BASE + 40));
        run_and_check("load_store");
    endtask

    task automatic test_control_flow();
        word_t x;
        begin_test();
        x = $random(seed);
        load_const(5'd1, DATA_BASE);
        load_const(5'd2, x);
        load_const(5'd3, x);
        load_const(5'd4, ~x);
        // Taken beq, the store right after is skipped
        i_type(OP_BEQ, 5'd3, 5'd2, 16'd1);
        i_type(OP_SW, 5'd2, 5'd1, 16'd0);
        store_expect(5'd2, 16'd4, x);
        // Not taken, both stores run
        i_type(OP_BEQ, 5'd4, 5'd2, 16'd1);
        store_expect(5'd4, 16'd8, ~x);
        store_expect(5'd4, 16'd12, ~x);
        // Jump over one store
        jump_to(prog_len + 2);
        i_type(OP_SW, 5'd2, 5'd1, 16'd16);
        store_expect(5'd3, 16'd20, x);
        run_and_check("control_flow");
    endtask

    initial begin
        test_reset_fetch();
        test_reg_alu();
        test_imm_ops();
        test_load_store();
        test_control_flow();
        if (mc_cpu_i.mem_port_checks_i.failed_excl
            || mc_cpu_i.mem_port_checks_i.failed_reset
            || mc_cpu_i.mem_port_checks_i.failed_align) begin
            $display("an assertion on the memory ports failed during the run");
            stop_on_failure();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== tb_mc_cpu_sva.sv ====
`timescale 1ns/1ps

module tb_mc_cpu_sva (
    input logic            clk,
    input logic            rst,
    input mips_pkg::word_t imem_addr_i,
    input logic            dmem_read_i,
    input logic            dmem_write_i
);

    // Sticky flags, one per property
    logic failed_excl  = 1'b0;
    logic failed_reset = 1'b0;
    logic failed_align = 1'b0;

    // A load and a store never share a cycle
    read_write_excl: assert property (
        @(posedge clk) disable iff (rst) !(dmem_read_i && dmem_write_i)
    ) else begin
        $error("dmem read and write strobes high in the same cycle");
        failed_excl = 1'b1;
    end

    quiet_in_reset: assert property (
        @(posedge clk) rst |-> (!dmem_read_i && !dmem_write_i)
    ) else begin
        $error("memory strobe high while reset is asserted");
        failed_reset = 1'b1;
    end

    fetch_aligned: assert property (
        @(posedge clk) disable iff (rst) imem_addr_i[1:0] == 2'b00
    ) else begin
        $error("fetch address not word aligned");
        failed_align = 1'b1;
    end

endmodule

bind mc_cpu tb_mc_cpu_sva mem_port_checks_i (
    .clk          (clk),
    .rst          (rst),
    .imem_addr_i  (imem_addr_o),
    .dmem_read_i  (dmem_read_o),
    .dmem_write_i (dmem_write_o)
);
